// ==== tb.f ====
common/core_cfg_pkg.sv
common/issue_pkg.sv
hw/regfile/int_regfile.sv
hw/issue/hazard_unit.sv
hw/issue/operand_mux.sv
hw/issue/ex_dispatch_regs.sv
hw/issue_read_operands.sv
verification/issue_asserts.sv
verification/issue_tb.sv

// ==== verification/issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_tb;

    import core_cfg_pkg::*;
    import issue_pkg::*;

    localparam int unsigned RST_CYCLES = 3;

    // one cycle of stimulus plus what the stage should answer
    typedef struct packed {
        sb_entry_t                                entry;
        logic                                     valid;
        clobber_t                                 clobber;
        fwd_t                                     rs1_fwd;
        fwd_t                                     rs2_fwd;
        logic                                     flu_ready;
        logic                                     lsu_ready;
        commit_port_t [NR_COMMIT_PORTS-1:0]       commit;
        logic                                     flush;
        // ack in the same cycle, pulse and payload one cycle later
        logic                                     exp_ack;
        fu_valid_t                                exp_valid;
        fu_data_t                                 exp_data;
    } row_t;

    localparam fu_valid_t NO_PULSE     = '0;
    localparam fu_valid_t PULSE_ALU    = '{alu: 1'b1, default: 1'b0};
    localparam fu_valid_t PULSE_BRANCH = '{branch: 1'b1, default: 1'b0};
    localparam fu_valid_t PULSE_LSU    = '{lsu: 1'b1, default: 1'b0};
    localparam fu_valid_t PULSE_MULT   = '{mult: 1'b1, default: 1'b0};
    localparam fu_valid_t PULSE_CSR    = '{csr: 1'b1, default: 1'b0};

    logic                               clk_i;
    logic                               rst_ni;
    logic                               flush;
    sb_entry_t                          issue_instr;
    logic                               issue_instr_valid;
    logic                               issue_ack;
    logic [REG_ADDR_W-1:0]              rs1_addr;
    logic [REG_ADDR_W-1:0]              rs2_addr;
    fwd_t                               rs1_fwd;
    fwd_t                               rs2_fwd;
    clobber_t                           rd_clobber;
    commit_port_t [NR_COMMIT_PORTS-1:0] commit;
    logic                               flu_ready;
    logic                               lsu_ready;
    fu_data_t                           fu_data;
    fu_valid_t                          fu_valid;

    row_t            tbl[$];
    row_t            cur;
    logic [15:0]     lfsr_state;
    int              cycle_cnt     = 0;
    int              timeout_limit = 1000;

    // random register contents, forward values, pc and immediate
    logic [XLEN-1:0] v_x3;
    logic [XLEN-1:0] v_x5;
    logic [XLEN-1:0] v_x7;
    logic [XLEN-1:0] v_x9;
    logic [XLEN-1:0] v_x9b;
    logic [XLEN-1:0] v_x11;
    logic [XLEN-1:0] junk;
    logic [XLEN-1:0] fwd_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] pc_val;
    logic [XLEN-1:0] imm_val;

    issue_read_operands u_dut (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush),
        .issue_instr_i       (issue_instr),
        .issue_instr_valid_i (issue_instr_valid),
        .issue_ack_o         (issue_ack),
        .rs1_o               (rs1_addr),
        .rs2_o               (rs2_addr),
        .rs1_fwd_i           (rs1_fwd),
        .rs2_fwd_i           (rs2_fwd),
        .rd_clobber_i        (rd_clobber),
        .commit_i            (commit),
        .flu_ready_i         (flu_ready),
        .lsu_ready_i         (lsu_ready),
        .fu_data_o           (fu_data),
        .fu_valid_o          (fu_valid)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------
    // random data
    // --------------------

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit of the word
    task automatic rand_word(output logic [XLEN-1:0] w);
        w = '0;
        for (int k = 0; k < XLEN; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // --------------------
    // table building
    // --------------------

    // nothing valid, units ready, no commits
    function automatic row_t idle_row();
        row_t r;
        r = '0;
        r.flu_ready = 1'b1;
        r.lsu_ready = 1'b1;
        r.exp_data  = FU_DATA_RST;
        return r;
    endfunction

    task automatic present_entry(input fu_t fu, input fu_op_t op,
                                 input logic [REG_ADDR_W-1:0] rs1,
                                 input logic [REG_ADDR_W-1:0] rs2,
                                 input logic [REG_ADDR_W-1:0] rd);
        cur.valid          = 1'b1;
        cur.entry          = '0;
        cur.entry.pc       = pc_val;
        cur.entry.trans_id = TRANS_ID_W'(tbl.size());
        cur.entry.fu       = fu;
        cur.entry.op       = op;
        cur.entry.rs1      = rs1;
        cur.entry.rs2      = rs2;
        cur.entry.rd       = rd;
        cur.entry.result   = imm_val;
    endtask

    // acked entry with its pulse and operands
    task automatic expect_issue(input fu_valid_t pulse, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b);
        cur.exp_ack   = 1'b1;
        cur.exp_valid = pulse;
        cur.exp_data  = '{fu: cur.entry.fu, operator: cur.entry.op, operand_a: a,
                          operand_b: b, imm: cur.entry.result,
                          trans_id: cur.entry.trans_id};
    endtask

    task automatic set_commits(input logic [REG_ADDR_W-1:0] a0, input logic [XLEN-1:0] d0,
                               input logic [REG_ADDR_W-1:0] a1, input logic [XLEN-1:0] d1);
        cur.commit[0] = '{we: 1'b1, waddr: a0, wdata: d0};
        cur.commit[1] = '{we: 1'b1, waddr: a1, wdata: d1};
    endtask

    task automatic push_row();
        tbl.push_back(cur);
        cur = idle_row();
    endtask

    task automatic build_table();
        lfsr_state = 16'd67;
        rand_word(v_x3);
        rand_word(v_x5);
        rand_word(v_x7);
        rand_word(v_x9);
        rand_word(v_x9b);
        rand_word(v_x11);
        rand_word(junk);
        rand_word(fwd_a);
        rand_word(fwd_b);
        rand_word(pc_val);
        rand_word(imm_val);
        cur = idle_row();
        // fill registers, x11 hit by both ports so port 1 wins
        set_commits(5'd3, v_x3, 5'd5, v_x5);
        push_row();
        set_commits(5'd7, v_x7, 5'd9, v_x9);
        push_row();
        set_commits(5'd11, junk, 5'd11, v_x11);
        push_row();
        // plain reads, x0 reads zero
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd1);
        expect_issue(PULSE_ALU, v_x3, v_x5);
        push_row();
        present_entry(ALU, SUB, 5'd7, 5'd0, 5'd2);
        expect_issue(PULSE_ALU, v_x7, '0);
        push_row();
        present_entry(ALU, XOR, 5'd0, 5'd11, 5'd2);
        expect_issue(PULSE_ALU, '0, v_x11);
        push_row();
        // both sources forwarded
        present_entry(ALU, AND, 5'd3, 5'd5, 5'd1);
        cur.clobber[3] = ALU;
        cur.clobber[5] = LOAD;
        cur.rs1_fwd    = '{value: fwd_a, valid: 1'b1};
        cur.rs2_fwd    = '{value: fwd_b, valid: 1'b1};
        expect_issue(PULSE_ALU, fwd_a, fwd_b);
        push_row();
        // result not ready yet
        present_entry(ALU, OR, 5'd7, 5'd5, 5'd1);
        cur.clobber[7] = MULT;
        push_row();
        // csr result is not forwarded to an alu op
        present_entry(ALU, OR, 5'd7, 5'd5, 5'd1);
        cur.clobber[7] = CSR;
        cur.rs1_fwd    = '{value: fwd_a, valid: 1'b1};
        push_row();
        // sfence may take it
        present_entry(CSR, SFENCE_VMA, 5'd7, 5'd9, 5'd0);
        cur.clobber[7] = CSR;
        cur.rs1_fwd    = '{value: fwd_a, valid: 1'b1};
        expect_issue(PULSE_CSR, fwd_a, v_x9);
        push_row();
        // pc as operand a
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd2);
        cur.entry.use_pc = 1'b1;
        expect_issue(PULSE_ALU, pc_val, v_x5);
        push_row();
        // zimm ignores the clobbered rs1
        present_entry(CSR, CSRRW, 5'd7, 5'd0, 5'd4);
        cur.entry.use_zimm = 1'b1;
        cur.clobber[7]     = MULT;
        expect_issue(PULSE_CSR, 32'd7, '0);
        push_row();
        // immediate in b, but not for store and branch
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd4);
        cur.entry.use_imm = 1'b1;
        expect_issue(PULSE_ALU, v_x3, imm_val);
        push_row();
        present_entry(STORE, SW, 5'd3, 5'd5, 5'd0);
        cur.entry.use_imm = 1'b1;
        expect_issue(PULSE_LSU, v_x3, v_x5);
        push_row();
        present_entry(CTRL_FLOW, JALR, 5'd7, 5'd5, 5'd1);
        cur.entry.use_imm = 1'b1;
        expect_issue(PULSE_BRANCH, v_x7, v_x5);
        push_row();
        // waw on rd, then the same with rd retiring this cycle
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd9);
        cur.clobber[9] = ALU;
        push_row();
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd9);
        cur.clobber[9] = ALU;
        cur.commit[1]  = '{we: 1'b1, waddr: 5'd9, wdata: v_x9b};
        expect_issue(PULSE_ALU, v_x3, v_x5);
        push_row();
        // excepted entry drains despite a stall, unit-less entry drains
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd1);
        cur.entry.ex_valid = 1'b1;
        cur.clobber[3]     = MULT;
        cur.exp_ack        = 1'b1;
        push_row();
        present_entry(NONE, ADD, 5'd3, 5'd5, 5'd1);
        cur.exp_ack = 1'b1;
        push_row();
        // back-pressure
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd1);
        cur.flu_ready = 1'b0;
        push_row();
        present_entry(LOAD, LW, 5'd3, 5'd0, 5'd8);
        cur.lsu_ready = 1'b0;
        push_row();
        // mult after mult goes, alu after mult waits a cycle
        present_entry(MULT, MUL, 5'd3, 5'd5, 5'd6);
        expect_issue(PULSE_MULT, v_x3, v_x5);
        push_row();
        present_entry(MULT, MUL, 5'd7, 5'd9, 5'd7);
        expect_issue(PULSE_MULT, v_x7, v_x9b);
        push_row();
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd1);
        push_row();
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd1);
        expect_issue(PULSE_ALU, v_x3, v_x5);
        push_row();
        // flush kills the pulse of this handshake
        present_entry(ALU, ADD, 5'd3, 5'd5, 5'd1);
        cur.flush   = 1'b1;
        cur.exp_ack = 1'b1;
        push_row();
        push_row();
    endtask

    // --------------------
    // drive and compare
    // --------------------
    task automatic drive_row(input row_t r);
        issue_instr       <= r.entry;
        issue_instr_valid <= r.valid;
        rd_clobber        <= r.clobber;
        rs1_fwd           <= r.rs1_fwd;
        rs2_fwd           <= r.rs2_fwd;
        flu_ready         <= r.flu_ready;
        lsu_ready         <= r.lsu_ready;
        commit            <= r.commit;
        flush             <= r.flush;
    endtask

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_ack(input logic got, input logic exp, input int row);
        if (got !== exp) begin
            report_error($sformatf("row %0d issue_ack_o is %b, expected %b", row, got, exp));
        end
    endtask

    // scoreboard lookup address, taken straight from the entry
    task automatic check_rs_addr(input logic [REG_ADDR_W-1:0] got,
                                 input logic [REG_ADDR_W-1:0] exp,
                                 input string port, input int row);
        if (got !== exp) begin
            report_error($sformatf("row %0d %s is %0d, expected %0d", row, port, got, exp));
        end
    endtask

    task automatic check_fu_valid(input fu_valid_t got, input fu_valid_t exp, input int row);
        if (got !== exp) begin
            report_error($sformatf("row %0d fu_valid_o is %b, expected %b", row, got, exp));
        end
    endtask

    task automatic check_fu_data(input fu_data_t got, input fu_data_t exp, input int row);
        if (got !== exp) begin
            report_error($sformatf("row %0d fu_data_o is %h, expected %h", row, got, exp));
        end
    endtask

    // hang guard
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: the run did not end within %0d cycles", timeout_limit);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_ni = 1'b0;
        drive_row(idle_row());
        build_table();
        timeout_limit = 4 * tbl.size() + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_fu_valid(fu_valid, NO_PULSE, -1);
        check_fu_data(fu_data, FU_DATA_RST, -1);
        // row i drives this cycle, row i-1 shows up on the outputs
        for (int i = 0; i <= tbl.size(); i++) begin
            @(posedge clk_i);
            if (i < tbl.size()) begin
                drive_row(tbl[i]);
            end else begin
                drive_row(idle_row());
            end
            @(negedge clk_i);
            if (i < tbl.size()) begin
                check_ack(issue_ack, tbl[i].exp_ack, i);
                check_rs_addr(rs1_addr, tbl[i].entry.rs1, "rs1_o", i);
                check_rs_addr(rs2_addr, tbl[i].entry.rs2, "rs2_o", i);
            end
            if (i > 0) begin
                check_fu_valid(fu_valid, tbl[i-1].exp_valid, i - 1);
                if (tbl[i-1].exp_valid != NO_PULSE) begin
                    check_fu_data(fu_data, tbl[i-1].exp_data, i - 1);
                end
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/issue_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_asserts (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 fire_i,
    // registered unit strobes
    input  issue_pkg::fu_valid_t fu_valid_i
);

    // --------------------
    // unit strobes
    // --------------------

    // one unit at a time
    onehot_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(fu_valid_i))
        else $error("more than one unit valid at once");

    // a strobe needs an accepted entry one cycle before
    valid_after_fire : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !fire_i |=> (fu_valid_i == '0))
        else $error("unit valid without a handshake in the cycle before");

    // flush wins over the handshake
    no_valid_after_flush : assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (fu_valid_i == '0))
        else $error("unit valid right after a flush");

endmodule

bind ex_dispatch_regs issue_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .fire_i     (fire_i),
    .fu_valid_i (fu_valid_o)
);

`default_nettype wire

// ==== hw/issue_read_operands.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_read_operands (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     flush_i,
    // entry from the scoreboard
    input  issue_pkg::sb_entry_t                     issue_instr_i,
    input  logic                                     issue_instr_valid_i,
    output logic                                     issue_ack_o,
    // scoreboard lookup of pending results
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]      rs1_o,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]      rs2_o,
    input  issue_pkg::fwd_t                          rs1_fwd_i,
    input  issue_pkg::fwd_t                          rs2_fwd_i,
    input  issue_pkg::clobber_t                      rd_clobber_i,
    // commit write ports
    input  issue_pkg::commit_port_t [core_cfg_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    // unit readiness
    input  logic                                     flu_ready_i,
    input  logic                                     lsu_ready_i,
    // toward execute
    output issue_pkg::fu_data_t                      fu_data_o,
    output issue_pkg::fu_valid_t                     fu_valid_o
);

    import issue_pkg::*;

    logic [1:0]      fwd_sel;
    logic [31:0]     rdata_a;
    logic [31:0]     rdata_b;
    fu_data_t        fu_data_n;
    logic            fire;
    logic            mult_pending;

    // scoreboard polls the source registers directly
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // accepted entry that really goes to a unit
    assign fire = issue_instr_valid_i & issue_ack_o & ~issue_instr_i.ex_valid;

    hazard_unit u_hazard (
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .rs1_fwd_valid_i     (rs1_fwd_i.valid),
        .rs2_fwd_valid_i     (rs2_fwd_i.valid),
        .rd_clobber_i        (rd_clobber_i),
        .commit_i            (commit_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .mult_pending_i      (mult_pending),
        .fwd_sel_o           (fwd_sel),
        .issue_ack_o         (issue_ack_o)
    );

    int_regfile u_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    operand_mux u_operand_mux (
        .issue_instr_i (issue_instr_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .rs1_fwd_i     (rs1_fwd_i),
        .rs2_fwd_i     (rs2_fwd_i),
        .fwd_sel_i     (fwd_sel),
        .fu_data_o     (fu_data_n)
    );

    ex_dispatch_regs u_dispatch (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .fire_i         (fire),
        .fu_i           (issue_instr_i.fu),
        .fu_data_i      (fu_data_n),
        .fu_data_o      (fu_data_o),
        .fu_valid_o     (fu_valid_o),
        .mult_pending_o (mult_pending)
    );

endmodule

`default_nettype wire

// ==== hw/issue/ex_dispatch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_dispatch_regs (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    // accepted entry headed for a unit
    input  logic                  fire_i,
    input  issue_pkg::fu_t        fu_i,
    input  issue_pkg::fu_data_t   fu_data_i,
    // registered payload and strobes
    output issue_pkg::fu_data_t   fu_data_o,
    output issue_pkg::fu_valid_t  fu_valid_o,
    output logic                  mult_pending_o
);

    import issue_pkg::*;

    fu_data_t  fu_data_q;
    fu_valid_t valid_d;
    fu_valid_t valid_q;

    // --------------------
    // unit select
    // --------------------
    always_comb begin : unit_select
        valid_d = '0;
        if (fire_i) begin
            case (fu_i)
                ALU:         valid_d.alu    = 1'b1;
                CTRL_FLOW:   valid_d.branch = 1'b1;
                MULT:        valid_d.mult   = 1'b1;
                LOAD, STORE: valid_d.lsu    = 1'b1;
                CSR:         valid_d.csr    = 1'b1;
                // NONE starts no unit
                default:     valid_d        = '0;
            endcase
        end
        // a flush kills the strobe of this cycle's handshake too
        if (flush_i) begin
            valid_d = '0;
        end
    end

    // --------------------
    // id/ex registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // payload reloads every cycle, strobes tell when it counts
    always_ff @(posedge clk_i or negedge rst_ni) begin : payload_reg
        if (!rst_ni) begin
            fu_data_q <= FU_DATA_RST;
        end else begin
            fu_data_q <= fu_data_i;
        end
    end

    assign fu_data_o      = fu_data_q;
    assign fu_valid_o     = valid_q;
    // locks the shared flu result bus for a cycle
    assign mult_pending_o = valid_q.mult;

endmodule

`default_nettype wire

// ==== hw/issue/operand_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_mux (
    input  issue_pkg::sb_entry_t                 issue_instr_i,
    // register file read data for rs1 and rs2
    input  logic [core_cfg_pkg::XLEN-1:0]        rdata_a_i,
    input  logic [core_cfg_pkg::XLEN-1:0]        rdata_b_i,
    input  issue_pkg::fwd_t                      rs1_fwd_i,
    input  issue_pkg::fwd_t                      rs2_fwd_i,
    input  logic [1:0]                           fwd_sel_i,
    // payload for the next cycle
    output issue_pkg::fu_data_t                  fu_data_o
);

    import core_cfg_pkg::*;
    import issue_pkg::*;

    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;

    // later assignments take priority
    always_comb begin : operand_select
        operand_a = rdata_a_i;
        operand_b = rdata_b_i;
        // pending results from the scoreboard
        if (fwd_sel_i[0]) begin
            operand_a = rs1_fwd_i.value;
        end
        if (fwd_sel_i[1]) begin
            operand_b = rs2_fwd_i.value;
        end
        // auipc, jal style
        if (issue_instr_i.use_pc) begin
            operand_a = issue_instr_i.pc;
        end
        // csr immediate, zero extended
        if (issue_instr_i.use_zimm) begin
            operand_a = {{(XLEN-REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
        end
        // store and branch keep rs2 and pass the offset in imm
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE)
                && (issue_instr_i.fu != CTRL_FLOW)) begin
            operand_b = issue_instr_i.result;
        end
    end

    assign fu_data_o.fu        = issue_instr_i.fu;
    assign fu_data_o.operator  = issue_instr_i.op;
    assign fu_data_o.operand_a = operand_a;
    assign fu_data_o.operand_b = operand_b;
    assign fu_data_o.imm       = issue_instr_i.result;
    assign fu_data_o.trans_id  = issue_instr_i.trans_id;

endmodule

`default_nettype wire

// ==== hw/issue/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  issue_pkg::sb_entry_t                     issue_instr_i,
    input  logic                                     issue_instr_valid_i,
    // forward data availability from the scoreboard
    input  logic                                     rs1_fwd_valid_i,
    input  logic                                     rs2_fwd_valid_i,
    input  issue_pkg::clobber_t                      rd_clobber_i,
    input  issue_pkg::commit_port_t [core_cfg_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                     flu_ready_i,
    input  logic                                     lsu_ready_i,
    // a mult pulse went out last cycle
    input  logic                                     mult_pending_i,
    // bit 0 forwards rs1, bit 1 forwards rs2
    output logic [1:0]                               fwd_sel_o,
    output logic                                     issue_ack_o
);

    import core_cfg_pkg::*;
    import issue_pkg::*;

    fu_t  rs1_owner;
    fu_t  rs2_owner;
    logic sfence;
    logic stall;
    logic fu_busy;
    logic rd_free;
    logic rd_committed;

    // pending writer of each source
    assign rs1_owner = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_owner = rd_clobber_i[issue_instr_i.rs2];
    // sfence may take a csr result from the scoreboard
    assign sfence    = (issue_instr_i.op == SFENCE_VMA);

    // --------------------
    // operand availability
    // --------------------
    always_comb begin : operands_available
        stall     = 1'b0;
        fwd_sel_o = 2'b00;
        // zimm lives in the rs1 field, nothing to wait on
        if (!issue_instr_i.use_zimm && (rs1_owner != NONE)) begin
            // csr results only come through the register file
            if (rs1_fwd_valid_i && ((rs1_owner != CSR) || sfence)) begin
                fwd_sel_o[0] = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_owner != NONE) begin
            if (rs2_fwd_valid_i && ((rs2_owner != CSR) || sfence)) begin
                fwd_sel_o[1] = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // --------------------
    // unit busy
    // --------------------
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // --------------------
    // waw check
    // --------------------
    assign rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);

    // commit retires the old writer of rd this very cycle
    always_comb begin : rd_commit_check
        rd_committed = 1'b0;
        for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == issue_instr_i.rd)) begin
                rd_committed = 1'b1;
            end
        end
    end

    // issue acknowledge
    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_committed)) begin
                issue_ack_o = 1'b1;
            end
            // excepted or unit-less entries just drain
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the fixed latency bus is taken by the multiplier
        if (mult_pending_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/regfile/int_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // two combinational read ports
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [core_cfg_pkg::XLEN-1:0]       rdata_a_o,
    output logic [core_cfg_pkg::XLEN-1:0]       rdata_b_o,
    // write ports from commit
    input  issue_pkg::commit_port_t [core_cfg_pkg::NR_COMMIT_PORTS-1:0] commit_i
);

    import core_cfg_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NR_REGS-1];

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
        if (!rst_ni) begin
            for (int r = 1; r < NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // ascending port order, the highest port wins a collision
            for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
                for (int r = 1; r < NR_REGS; r++) begin
                    if (commit_i[i].we && (commit_i[i].waddr == REG_ADDR_W'(r))) begin
                        regs_q[r] <= commit_i[i].wdata;
                    end
                end
            end
        end
    end

    // --------------------
    // read side
    // --------------------
    // no bypass, a write shows up one cycle later
    always_comb begin : reg_read
        rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
        rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];
    end

endmodule

`default_nettype wire

// ==== common/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    import core_cfg_pkg::*;

    // --------------------
    // unit and operator codes
    // --------------------

    // target functional unit of an entry
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        MULT,
        LOAD,
        STORE,
        CSR
    } fu_t;

    // operator handed to the functional unit
    typedef enum logic [5:0] {
        // alu
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLTS, SLTU,
        // branches and jumps
        EQ, NE, JALR,
        // multiplier
        MUL, MULH, DIV, REM,
        // load / store
        LW, LH, LB, SW, SH, SB,
        // csr and fences
        CSRRW, CSRRS, CSRRC, SFENCE_VMA
    } fu_op_t;

    // --------------------
    // issue side
    // --------------------

    // one scoreboard entry as presented to issue
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [TRANS_ID_W-1:0] trans_id;
        fu_t                   fu;
        fu_op_t                op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        // holds the decoded immediate at this point
        logic [XLEN-1:0]       result;
        logic                  use_imm;
        logic                  use_pc;
        logic                  use_zimm;
        // entry already carries an exception
        logic                  ex_valid;
    } sb_entry_t;

    // forwarded result from the scoreboard
    typedef struct packed {
        logic [XLEN-1:0] value;
        logic            valid;
    } fwd_t;

    // register write from commit
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } commit_port_t;

    // pending writer per register, NONE when free
    typedef fu_t [NR_REGS-1:0] clobber_t;

    // --------------------
    // execute side
    // --------------------

    // payload toward the functional units
    typedef struct packed {
        fu_t                   fu;
        fu_op_t                operator;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       imm;
        logic [TRANS_ID_W-1:0] trans_id;
    } fu_data_t;

    // one start strobe per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

    // idle payload, also seen right after reset
    localparam fu_data_t FU_DATA_RST = '{
        fu:        NONE,
        operator:  ADD,
        operand_a: '0,
        operand_b: '0,
        imm:       '0,
        trans_id:  '0
    };

endpackage

`default_nettype wire

// ==== common/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

    // --------------------
    // datapath widths
    // --------------------

    // integer datapath width
    localparam int unsigned XLEN = 32;

    // register specifier width, x0..x31
    localparam int unsigned REG_ADDR_W = 5;
    // number of architectural integer registers
    localparam int unsigned NR_REGS = 32;

    // --------------------
    // scoreboard and commit
    // --------------------

    // tag width of a scoreboard slot
    localparam int unsigned TRANS_ID_W = 3;
    // write ports coming back from commit
    localparam int unsigned NR_COMMIT_PORTS = 2;

endpackage

`default_nettype wire
